// ==== logic/uart_defines.svh ====
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// Clock cycles in one bit period on tx and rx.
`define UART_BAUD_DIV 434

// Idle bit periods between the header frame and the data frame of a write.
`define UART_GAP_BITS 16

// Bit periods the master waits for the start bit of a read reply.
`define UART_REPLY_TIMEOUT_BITS 64

`endif

// ==== logic/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

  typedef struct packed {
    logic       is_write;  // Set for a write, clear for a read.
    logic [6:0] addr;
    logic [7:0] data;      // Only sent by writes.
  } cmd_t;

  typedef struct packed {
    logic [7:0] data;
    logic       parity_ok;
    logic       stop_ok;
  } rx_frame_t;

  typedef enum logic [1:0] {
    resp_ok,
    resp_parity_err,
    resp_frame_err,
    resp_timeout
  } resp_status_e;

  typedef struct packed {
    resp_status_e status;
    logic [7:0]   data;    // Zero when the reply timed out.
  } read_resp_t;

  typedef enum logic [2:0] {
    st_idle,
    st_send_header,
    st_gap,
    st_send_data,
    st_wait_reply,
    st_receive,
    st_report
  } ctrl_state_e;

endpackage

`default_nettype wire

// ==== logic/uart_tx_frame.sv ====
`default_nettype none
`include "uart_defines.svh"

module uart_tx_frame (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        tx_start,
  input  wire  [7:0] tx_byte,
  output logic       tx,
  output logic       tx_busy,
  output logic       tx_done
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIV - 1);

  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       byte_q;
  logic [10:0]      frame;
  logic             bit_end;

  assign frame   = {1'b1, ^byte_q, byte_q, 1'b0}; // Stop, even parity, data, start.
  assign bit_end = tx_busy && (baud_cnt == CNT_LAST);
  assign tx_done = bit_end && (bit_idx == 4'd10); // Last cycle of the stop bit.

  always_ff @(posedge clk)
  begin
    if (tx_start && !tx_busy)
    begin
      byte_q <= tx_byte;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx       <= 1'b1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else if (!tx_busy)
    begin
      baud_cnt <= '0;
      bit_idx  <= '0;
      if (tx_start)
      begin
        tx      <= 1'b0; // Start bit goes out on the next cycle.
        tx_busy <= 1'b1;
      end
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == 4'd10)
      begin
        tx_busy <= 1'b0;
        tx      <= 1'b1;
      end
      else
      begin
        bit_idx <= bit_idx + 4'd1;
        tx      <= frame[bit_idx + 4'd1];
      end
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  // The controller must wait for the current frame to end.
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n) tx_start |-> !tx_busy
  );

endmodule

`default_nettype wire

// ==== logic/uart_rx_frame.sv ====
`default_nettype none
`include "uart_defines.svh"

module uart_rx_frame (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     rx,
  input  wire                     rx_arm,
  output logic                    rx_busy,
  output logic                    rx_done,
  output uart_pkg::rx_frame_t     rx_frame
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`UART_BAUD_DIV / 2 - 1);

  logic [1:0]       rx_sync;
  logic             rx_s;
  logic             rx_s_d;
  logic             fall;
  logic             hunting;
  logic             sample;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_idx;
  logic [7:0]       shift_q;
  logic             parity_q;

  assign rx_s   = rx_sync[1];
  assign fall   = rx_s_d && !rx_s;
  assign sample = rx_arm && rx_busy && (baud_cnt == CNT_LAST); // Middle of a bit.

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_sync <= 2'b11;
      rx_s_d  <= 1'b1;
    end
    else
    begin
      rx_sync <= {rx_sync[0], rx};
      rx_s_d  <= rx_s;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hunting  <= 1'b0;
      rx_busy  <= 1'b0;
      rx_done  <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
    end
    else
    begin
      rx_done <= 1'b0;
      if (!rx_arm)
      begin
        hunting  <= 1'b0;
        rx_busy  <= 1'b0;
        baud_cnt <= '0;
      end
      else if (hunting)
      begin
        if (baud_cnt == CNT_HALF)
        begin
          baud_cnt <= '0;
          hunting  <= 1'b0;
          rx_busy  <= !rx_s; // A high line here was a glitch.
          bit_idx  <= '0;
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
      else if (rx_busy)
      begin
        if (sample)
        begin
          baud_cnt <= '0;
          bit_idx  <= bit_idx + 4'd1;
          if (bit_idx == 4'd9)
          begin
            rx_busy <= 1'b0;
            rx_done <= 1'b1;
          end
        end
        else
        begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
      else if (fall)
      begin
        hunting  <= 1'b1;
        baud_cnt <= '0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (bit_idx < 4'd8)
      begin
        shift_q <= {rx_s, shift_q[7:1]}; // Data arrives LSB first.
      end
      else if (bit_idx == 4'd8)
      begin
        parity_q <= rx_s;
      end
      else
      begin
        rx_frame.data      <= shift_q;
        rx_frame.parity_ok <= ~^{shift_q, parity_q};
        rx_frame.stop_ok   <= rx_s;
      end
    end
  end

  a_done_single: assert property (
    @(posedge clk) disable iff (!rst_n) rx_done |=> !rx_done
  );

endmodule

`default_nettype wire

// ==== logic/uart_cmd_ctrl.sv ====
`default_nettype none
`include "uart_defines.svh"

module uart_cmd_ctrl (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire uart_pkg::cmd_t    cmd,
  input  wire                    cmd_vld,
  input  wire                    tx_busy,
  input  wire                    tx_done,
  input  wire                    rx_busy,
  input  wire                    rx_done,
  input  wire uart_pkg::rx_frame_t rx_frame,
  output logic                   cmd_rdy,
  output logic                   tx_start,
  output logic [7:0]             tx_byte,
  output logic                   rx_arm,
  output logic                   read_rdy,
  output uart_pkg::read_resp_t   read_resp
);

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIV - 1);
  localparam int BITS_MAX = (`UART_REPLY_TIMEOUT_BITS > `UART_GAP_BITS) ?
                            `UART_REPLY_TIMEOUT_BITS : `UART_GAP_BITS;
  localparam int BIT_W = $clog2(BITS_MAX);
  localparam logic [BIT_W-1:0] GAP_LAST     = BIT_W'(`UART_GAP_BITS - 1);
  localparam logic [BIT_W-1:0] TIMEOUT_LAST = BIT_W'(`UART_REPLY_TIMEOUT_BITS - 1);

  uart_pkg::ctrl_state_e  state;
  uart_pkg::cmd_t         cmd_q;
  uart_pkg::resp_status_e rx_status;
  logic [CNT_W-1:0]       baud_cnt;
  logic [BIT_W-1:0]       bit_cnt;
  logic                   timing;
  logic                   tick;
  logic                   gap_end;
  logic                   reply_late;

  assign cmd_rdy  = (state == uart_pkg::st_idle);
  assign rx_arm   = (state == uart_pkg::st_wait_reply) || (state == uart_pkg::st_receive);
  assign read_rdy = (state == uart_pkg::st_report);

  // The gap and the reply timeout share one bit-period timer.
  assign timing     = (state == uart_pkg::st_gap) || (state == uart_pkg::st_wait_reply);
  assign tick       = timing && (baud_cnt == CNT_LAST);
  assign gap_end    = (state == uart_pkg::st_gap) && tick && (bit_cnt == GAP_LAST) && !tx_busy;
  assign reply_late = (state == uart_pkg::st_wait_reply) && !rx_busy && tick &&
                      (bit_cnt == TIMEOUT_LAST);

  always_comb
  begin
    if (!rx_frame.stop_ok)
      rx_status = uart_pkg::resp_frame_err; // A bad stop bit outranks parity.
    else if (!rx_frame.parity_ok)
      rx_status = uart_pkg::resp_parity_err;
    else
      rx_status = uart_pkg::resp_ok;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (!timing)
    begin
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (tick)
    begin
      baud_cnt <= '0;
      bit_cnt  <= bit_cnt + 1'b1;
    end
    else
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_pkg::st_idle;
      tx_start <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      case (state)
        uart_pkg::st_idle:
          if (cmd_vld)
          begin
            state    <= uart_pkg::st_send_header;
            tx_start <= 1'b1;
          end
        uart_pkg::st_send_header:
          if (tx_done)
            state <= cmd_q.is_write ? uart_pkg::st_gap : uart_pkg::st_wait_reply;
        uart_pkg::st_gap:
          if (gap_end)
          begin
            state    <= uart_pkg::st_send_data;
            tx_start <= 1'b1;
          end
        uart_pkg::st_send_data:
          if (tx_done)
            state <= uart_pkg::st_idle;
        uart_pkg::st_wait_reply:
          if (rx_busy)
            state <= uart_pkg::st_receive;
          else if (reply_late)
            state <= uart_pkg::st_report;
        uart_pkg::st_receive:
          if (rx_done)
            state <= uart_pkg::st_report;
        default:
          state <= uart_pkg::st_idle; // st_report lasts one cycle.
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (cmd_rdy && cmd_vld)
    begin
      cmd_q   <= cmd;
      tx_byte <= {cmd.is_write, cmd.addr};
    end
    else if (gap_end)
    begin
      tx_byte <= cmd_q.data;
    end
    if (reply_late)
    begin
      read_resp.status <= uart_pkg::resp_timeout;
      read_resp.data   <= '0;
    end
    else if ((state == uart_pkg::st_receive) && rx_done)
    begin
      read_resp.status <= rx_status;
      read_resp.data   <= rx_frame.data;
    end
  end

  a_rdy_low_while_tx: assert property (
    @(posedge clk) disable iff (!rst_n) tx_busy |-> !cmd_rdy
  );

  a_read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy
  );

endmodule

`default_nettype wire

// ==== logic/uart_cmd_master.sv ====
`default_nettype none

module uart_cmd_master (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire uart_pkg::cmd_t  cmd,
  input  wire                  cmd_vld,
  input  wire                  rx,
  output logic                 cmd_rdy,
  output logic                 tx,
  output logic                 read_rdy,
  output uart_pkg::read_resp_t read_resp
);

  logic                tx_start;
  logic [7:0]          tx_byte;
  logic                tx_busy;
  logic                tx_done;
  logic                rx_arm;
  logic                rx_busy;
  logic                rx_done;
  uart_pkg::rx_frame_t rx_frame;

  uart_cmd_ctrl ctrl0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done),
    .rx_busy   (rx_busy),
    .rx_done   (rx_done),
    .rx_frame  (rx_frame),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .rx_arm    (rx_arm),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  uart_tx_frame tx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy),
    .tx_done  (tx_done)
  );

  uart_rx_frame rx0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_arm   (rx_arm),
    .rx_busy  (rx_busy),
    .rx_done  (rx_done),
    .rx_frame (rx_frame)
  );

endmodule

`default_nettype wire

// ==== tests/uart_cmd_master_tb.sv ====
`default_nettype none
`include "uart_defines.svh"

module uart_cmd_master_tb;

  localparam int BIT            = `UART_BAUD_DIV;
  localparam int GAP_BITS       = `UART_GAP_BITS;
  localparam int FRAME_WAIT     = (11 + `UART_GAP_BITS + 8) * `UART_BAUD_DIV;
  localparam int RESP_WAIT      = (`UART_REPLY_TIMEOUT_BITS + 16) * `UART_BAUD_DIV;
  localparam int CMD_WAIT       = 40 * `UART_BAUD_DIV;
  localparam int IDLE_POLL      = 1000;
  localparam int NO_CORRUPT     = 0;
  localparam int CORRUPT_PARITY = 1;
  localparam int CORRUPT_STOP   = 2;

  logic                 clk = 1'b0;
  logic                 rst_n;
  uart_pkg::cmd_t       cmd;
  logic                 cmd_vld;
  logic                 rx;
  logic                 cmd_rdy;
  logic                 tx;
  logic                 read_rdy;
  uart_pkg::read_resp_t read_resp;

  int                   seed = 32'h7c50baac;
  string                test_name = "reset";
  longint               cycle = 0;
  int                   frames_seen = 0;
  int                   accept_count = 0;
  int                   accept_frames = 0;
  int                   resp_count = 0;
  logic [7:0]           line_bytes[$];
  longint               line_starts[$];
  uart_pkg::read_resp_t exp_resp_q[$];

  uart_cmd_master dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd       (cmd),
    .cmd_vld   (cmd_vld),
    .rx        (rx),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_resp (read_resp)
  );

  always #20 clk = ~clk;

  always @(posedge clk)
  begin
    cycle <= cycle + 1;
    if (rst_n && cmd_vld && cmd_rdy)
    begin
      accept_count  <= accept_count + 1;
      accept_frames <= frames_seen; // Frames already on the line when this command went in.
    end
  end

  task automatic abort_run;
    $display("Simulation failed");
    $fatal(1, "Stopped at the first error.");
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    abort_run();
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      $display("** Error: %s expected 8'h%02h, actual 8'h%02h", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("** Error: %s expected %b, actual %b", name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_resp(input string name, input uart_pkg::read_resp_t exp,
                            input uart_pkg::read_resp_t act);
    if (act !== exp)
    begin
      $display("** Error: %s expected status %0d data 8'h%02h, actual status %0d data 8'h%02h",
               name, exp.status, exp.data, act.status, act.data);
      abort_run();
    end
  endtask

  function automatic logic even_parity(input logic [7:0] b);
    int i;
    int ones;
    ones = 0;
    for (i = 0; i < 8; i++)
    begin
      if (b[i])
        ones++;
    end
    return ones[0];
  endfunction

  function automatic uart_pkg::read_resp_t expected_resp(input logic [7:0] reply,
                                                         input int corrupt, input bit no_reply);
    uart_pkg::read_resp_t r;
    r.data = reply;
    if (no_reply)
    begin
      r.status = uart_pkg::resp_timeout;
      r.data   = '0;
    end
    else if (corrupt == CORRUPT_STOP)
      r.status = uart_pkg::resp_frame_err; // A bad stop bit wins over bad parity.
    else if (corrupt == CORRUPT_PARITY)
      r.status = uart_pkg::resp_parity_err;
    else
      r.status = uart_pkg::resp_ok;
    return r;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Finds a start bit on tx and samples every later bit at its middle.
  task automatic decode_frame(output bit found, output logic [7:0] b, output logic p,
                              output logic s, output longint t0);
    int n;
    int i;
    found = 1'b0;
    n = 0;
    while (tx !== 1'b0 && n < IDLE_POLL)
    begin
      @(negedge clk);
      n++;
    end
    if (tx === 1'b0)
    begin
      found = 1'b1;
      t0 = cycle;
      wait_cycles(BIT / 2);
      if (tx !== 1'b0)
        report_failure("start bit on tx ended before mid-bit");
      for (i = 0; i < 8; i++)
      begin
        wait_cycles(BIT);
        b[i] = tx;
      end
      wait_cycles(BIT);
      p = tx;
      wait_cycles(BIT);
      s = tx;
    end
  endtask

  task automatic watch_line;
    logic [7:0] b;
    logic       p;
    logic       s;
    longint     t0;
    bit         found;
    forever
    begin
      decode_frame(found, b, p, s, t0);
      if (found)
      begin
        check_bit({test_name, " parity bit"}, even_parity(b), p);
        check_bit({test_name, " stop bit"}, 1'b1, s);
        line_bytes.push_back(b);
        line_starts.push_back(t0);
        frames_seen = frames_seen + 1;
      end
    end
  endtask

  // Compares each read_rdy pulse with the oldest expected response.
  always @(negedge clk)
  begin
    if (rst_n && read_rdy === 1'b1)
    begin
      if (exp_resp_q.size() == 0)
        report_failure("read_rdy pulsed with no read outstanding");
      else
      begin
        check_resp(test_name, exp_resp_q.pop_front(), read_resp);
        resp_count = resp_count + 1;
      end
    end
  end

  task automatic take_frame(output logic [7:0] b, output longint t0);
    int n;
    n = 0;
    while (line_bytes.size() == 0 && n < FRAME_WAIT)
    begin
      @(negedge clk);
      n++;
    end
    if (line_bytes.size() == 0)
      report_failure("no frame appeared on tx");
    b  = line_bytes.pop_front();
    t0 = line_starts.pop_front();
  endtask

  task automatic send_cmd(input uart_pkg::cmd_t c);
    int n;
    n = 0;
    @(negedge clk);
    cmd     = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy && n < CMD_WAIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
      report_failure("cmd_rdy never went high to take the command");
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    while (!cmd_rdy && n < 4 * BIT)
    begin
      @(negedge clk);
      n++;
    end
    if (!cmd_rdy)
      report_failure("cmd_rdy did not return high after the command");
    if (line_bytes.size() != 0)
      report_failure("tx carried a frame that no command asked for");
  endtask

  task automatic drive_reply(input logic [7:0] b, input int corrupt);
    int i;
    rx = 1'b0;
    wait_cycles(BIT);
    for (i = 0; i < 8; i++)
    begin
      rx = b[i];
      wait_cycles(BIT);
    end
    rx = even_parity(b) ^ (corrupt == CORRUPT_PARITY);
    wait_cycles(BIT);
    rx = (corrupt != CORRUPT_STOP);
    wait_cycles(BIT);
    rx = 1'b1;
  endtask

  task automatic check_write_frames(input uart_pkg::cmd_t c);
    logic [7:0] hb;
    logic [7:0] db;
    longint     t0;
    longint     t1;
    take_frame(hb, t0);
    check_byte({test_name, " header"}, {1'b1, c.addr}, hb);
    take_frame(db, t1);
    check_byte({test_name, " data"}, c.data, db);
    if (t1 - t0 < longint'((11 + GAP_BITS) * BIT))
      report_failure("idle gap between the two write frames was too short");
  endtask

  task automatic run_write(input uart_pkg::cmd_t c);
    c.is_write = 1'b1;
    send_cmd(c);
    check_write_frames(c);
    wait_idle();
  endtask

  task automatic run_read(input uart_pkg::cmd_t c, input logic [7:0] reply,
                          input int corrupt, input bit no_reply);
    logic [7:0] hb;
    longint     t0;
    int         n0;
    int         n;
    c.is_write = 1'b0;
    exp_resp_q.push_back(expected_resp(reply, corrupt, no_reply));
    n0 = resp_count;
    send_cmd(c);
    take_frame(hb, t0);
    check_byte({test_name, " header"}, {1'b0, c.addr}, hb);
    if (!no_reply)
    begin
      wait_cycles(BIT); // The receiver is armed once the header's stop bit ends.
      drive_reply(reply, corrupt);
    end
    n = 0;
    while (resp_count == n0 && n < RESP_WAIT)
    begin
      @(negedge clk);
      n++;
    end
    if (resp_count == n0)
      report_failure("read_rdy did not pulse for the read");
    wait_idle();
  endtask

  initial
  begin
    uart_pkg::cmd_t c;
    uart_pkg::cmd_t b;
    int             i;
    int             n;
    int             acc0;
    int             f0;
    rst_n   = 1'b0;
    cmd     = '0;
    cmd_vld = 1'b0;
    rx      = 1'b1;
    wait_cycles(5);
    rst_n = 1'b1;
    @(negedge clk);
    check_bit("reset tx", 1'b1, tx);
    check_bit("reset cmd_rdy", 1'b1, cmd_rdy);
    check_bit("reset read_rdy", 1'b0, read_rdy);
    for (i = 0; i < 20; i++)
    begin
      @(negedge clk);
      check_bit("reset idle tx", 1'b1, tx);
    end
    fork
      watch_line();
    join_none

    test_name = "random writes";
    for (i = 0; i < 20; i++)
    begin
      c = 16'($random(seed));
      run_write(c);
    end

    test_name = "good reads";
    for (i = 0; i < 6; i++)
    begin
      c = 16'($random(seed));
      run_read(c, 8'($random(seed)), NO_CORRUPT, 1'b0);
    end

    test_name = "parity error reads";
    for (i = 0; i < 2; i++)
    begin
      c = 16'($random(seed));
      run_read(c, 8'($random(seed)), CORRUPT_PARITY, 1'b0);
    end

    test_name = "frame error reads";
    for (i = 0; i < 2; i++)
    begin
      c = 16'($random(seed));
      run_read(c, 8'($random(seed)), CORRUPT_STOP, 1'b0);
    end

    test_name = "no reply read";
    c = 16'($random(seed));
    run_read(c, 8'($random(seed)), NO_CORRUPT, 1'b1);

    test_name = "back pressure";
    c = 16'($random(seed));
    c.is_write = 1'b1;
    b = c;
    b.addr = ~c.addr;
    b.data = ~c.data;
    f0 = frames_seen;
    send_cmd(c);
    acc0 = accept_count;
    cmd     = b; // Held valid for the whole of the first command.
    cmd_vld = 1'b1;
    check_write_frames(c);
    n = 0;
    while (accept_count == acc0 && n < CMD_WAIT)
    begin
      @(negedge clk);
      n++;
    end
    if (accept_count == acc0)
      report_failure("the held command was never accepted");
    @(negedge clk); // Valid stays up one more cycle, after cmd_rdy has dropped.
    cmd_vld = 1'b0;
    if (accept_frames - f0 != 2)
      report_failure("the held command was accepted before the running one finished");
    check_write_frames(b);
    wait_idle();
    if (accept_count != acc0 + 1)
      report_failure("the held command was accepted more than once");

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/uart_pkg.sv
logic/uart_tx_frame.sv
logic/uart_rx_frame.sv
logic/uart_cmd_ctrl.sv
logic/uart_cmd_master.sv
tests/uart_cmd_master_tb.sv
